/* verilog.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/control_unit.sv
verilog/imm_decode.sv
verilog/register_file.sv
verilog/alu.sv
verilog/next_pc_unit.sv
verilog/data_mem.sv
verilog/cpu.sv
dv/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the cpu testbench with verilator, runs it into sim.log and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module cpu_tb -o cpu_tb_sim > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

# a crash or a stop on an assertion counts as a failed run
./obj_dir/cpu_tb_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log

grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* dv/cpu_tb.sv */
// testbench for the single-cycle RV32I core
// serves fetch from a program table and checks pc and dnpc of every instruction
`timescale 1ns/100ps

module cpu_tb;

    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [31:0] nop_word = 32'h0000_0013;   // addi x0, x0, 0

    logic        clk;
    logic        arst_n;
    logic [31:0] cmd;
    logic [31:0] pc;
    logic [31:0] dnpc;

    logic [31:0] prog [0:127];      // instruction per row, row = pc / 4
    logic [31:0] exp_dnpc [0:127];  // hand-worked next pc per row
    logic [31:0] exp_pc;
    int          n_rows;
    int          row;
    int          value_errors;
    int          other_errors;
    int          cycles;
    int          cycle_limit;
    logic        running;

    cpu cpu_i (.clk(clk), .arst_n(arst_n), .cmd(cmd), .pc(pc), .dnpc(dnpc));

    always #5 clk = ~clk;   // 10 ns period

    // instruction encoders, fields in assembler order
    function automatic logic [31:0] rtype(input int f3, input int alt,
                                          input int rd, input int rs1, input int rs2);
        return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] op, input int f3,
                                          input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] stype(input int f3, input int base,
                                          input int src, input int imm);
        return {imm[11:5], src[4:0], base[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input int f3, input int rs1,
                                          input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input logic [6:0] op, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] jtype(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // row that falls through to pc + 4
    task automatic step_row(input logic [31:0] instr);
        prog[n_rows]     = instr;
        exp_dnpc[n_rows] = (n_rows + 1) * 4;
        n_rows++;
    endtask

    // row whose next pc is a number of rows away
    task automatic jump_row(input logic [31:0] instr, input int rows);
        prog[n_rows]     = instr;
        exp_dnpc[n_rows] = (n_rows + rows) * 4;
        n_rows++;
    endtask

    task automatic load_program();
        n_rows = 0;
        step_row(32'h0000_000f);                     // fence, no-op
        step_row(32'h0000_007b);                     // unknown opcode, no-op
        step_row(itype(op_imm, 0, 1, 0, -8));        // x1 = -8
        step_row(itype(op_imm, 0, 2, 0, 3));         // x2 = 3
        step_row(itype(op_imm, 0, 11, 0, -5));       // x11 = -5
        step_row(itype(op_imm, 0, 22, 0, -1));
        step_row(itype(op_imm, 0, 24, 0, 1));
        step_row(rtype(0, 0, 3, 1, 2));              // add  -> -5
        step_row(rtype(0, 1, 4, 11, 1));             // sub  -> 3
        step_row(rtype(5, 1, 7, 1, 2));              // sra  -> -1
        step_row(rtype(1, 0, 5, 7, 2));              // sll  -> -8
        step_row(rtype(5, 0, 6, 1, 2));              // srl  -> 0x1fffffff
        step_row(utype(op_lui, 14, 'h20000));        // 0x20000000
        step_row(itype(op_imm, 0, 23, 14, -1));      // 0x1fffffff
        step_row(utype(op_auipc, 15, 'h20000));      // row 14, pc 56
        step_row(itype(op_imm, 0, 26, 14, 56));
        step_row(rtype(2, 0, 8, 1, 2));              // slt  -> 1
        step_row(rtype(3, 0, 9, 1, 2));              // sltu -> 0
        step_row(rtype(4, 0, 10, 1, 11));            // xor  -> 3
        step_row(rtype(6, 0, 12, 1, 11));            // or   -> -5
        step_row(rtype(7, 0, 13, 1, 2));             // and  -> 0
        step_row(itype(op_imm, 0, 0, 0, 5));         // write to x0
        // zigzag triples, order r, r+2, r+1, r+3
        jump_row(btype(0, 3, 11, 8), 2);
        jump_row(btype(0, 5, 1, 8), 2);
        jump_row(btype(0, 4, 2, -4), -1);
        jump_row(btype(0, 7, 22, 8), 2);
        jump_row(btype(0, 15, 26, 8), 2);            // auipc
        jump_row(btype(0, 6, 23, -4), -1);           // srl against lui
        jump_row(btype(0, 8, 24, 8), 2);
        jump_row(btype(0, 10, 2, 8), 2);
        jump_row(btype(0, 9, 0, -4), -1);
        jump_row(btype(0, 12, 11, 8), 2);
        jump_row(btype(0, 0, 13, 8), 2);             // x0 still zero
        jump_row(btype(0, 13, 0, -4), -1);
        step_row(btype(0, 1, 2, 8));                 // beq  not taken
        step_row(btype(1, 1, 1, 8));                 // bne  not taken
        step_row(btype(4, 2, 1, 8));                 // blt  3 < -8 false
        step_row(btype(5, 1, 2, 8));                 // bge  -8 >= 3 false
        step_row(btype(6, 1, 2, 8));                 // bltu big < 3 false
        step_row(btype(7, 2, 1, 8));                 // bgeu 3 >= big false
        jump_row(btype(1, 1, 2, 8), 2);              // bne  taken
        jump_row(btype(5, 2, 1, 8), 2);              // bge  taken
        jump_row(btype(4, 1, 2, -4), -1);            // blt  taken
        jump_row(btype(6, 2, 1, 8), 2);              // bltu taken
        jump_row(btype(0, 2, 2, 8), 2);              // beq  taken
        jump_row(btype(7, 1, 2, -4), -1);            // bgeu taken
        jump_row(jtype(16, 8), 2);                   // jal x16, link 188
        jump_row(jtype(0, 8), 2);                    // return lands here
        jump_row(itype(op_jalr, 0, 17, 16, 1), -1);  // odd offset, back to 188
        step_row(itype(op_imm, 0, 3, 0, 196));       // jalr link value
        step_row(itype(op_imm, 0, 18, 0, 256));      // data base
        step_row(stype(2, 18, 1, 0));                // sw -> fffffff8
        step_row(stype(1, 18, 2, 2));                // sh -> 0003fff8
        step_row(stype(0, 18, 11, 1));               // sb -> 0003fbf8
        step_row(itype(op_load, 2, 19, 18, 0));      // lw
        step_row(itype(op_load, 1, 20, 18, 0));      // lh  -> fffffbf8
        step_row(itype(op_load, 5, 21, 18, 0));      // lhu -> 0000fbf8
        step_row(itype(op_load, 0, 25, 18, 1));      // lb  -> -5
        step_row(itype(op_load, 4, 27, 18, 1));      // lbu -> 251
        step_row(utype(op_lui, 28, 'h40));
        step_row(itype(op_imm, 0, 28, 28, -1032));   // 0x0003fbf8
        step_row(itype(op_imm, 0, 29, 0, -1032));
        step_row(utype(op_lui, 30, 'h10));
        step_row(itype(op_imm, 0, 30, 30, -1032));   // 0x0000fbf8
        step_row(itype(op_imm, 0, 31, 0, 251));
        jump_row(btype(0, 17, 3, 8), 2);
        jump_row(btype(0, 20, 29, 8), 2);
        jump_row(btype(0, 19, 28, -4), -1);
        jump_row(btype(0, 21, 30, 8), 2);
        jump_row(btype(0, 27, 31, 8), 2);
        jump_row(btype(0, 25, 11, -4), -1);
        jump_row(jtype(0, 0), 0);                    // self loop, end of program
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // run limit from table length and reset
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, program did not finish after %0d cycles", cycles);
            other_errors++;
            finish_run();
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        cmd          = nop_word;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        load_program();
        cycle_limit  = 2 * n_rows + 10 + 20;
        repeat (10) @(posedge clk);
        #1;
        arst_n  = 1'b1;
        exp_pc  = 32'h0;    // reset pc
        running = 1'b1;
        while (running) begin
            row = int'(pc >> 2);
            assert (pc == exp_pc) else begin
                $display("Error: time %0t, pc expected %h, actual %h", $time, exp_pc, pc);
                value_errors++;
            end
            if (row < 0 || row >= n_rows) begin
                $display("pc %h left the program at time %0t", pc, $time);
                other_errors++;
                running = 1'b0;
            end else begin
                cmd = prog[row];
                @(negedge clk);     // dnpc settled mid cycle
                assert (dnpc == exp_dnpc[row]) else begin
                    $display("Error: time %0t, dnpc expected %h, actual %h (row %0d)",
                             $time, exp_dnpc[row], dnpc, row);
                    value_errors++;
                end
                exp_pc = exp_dnpc[row];
                if (row == n_rows - 1) begin
                    running = 1'b0;
                end else begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        finish_run();
    end

endmodule

/* verilog/cpu.sv */
// single-cycle RV32I core top
// one instruction retired per clk edge, fetch is served from outside on cmd
`timescale 1ns/100ps

module cpu (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_isa_pkg::word_t cmd,
    output rv_isa_pkg::word_t pc,
    output rv_isa_pkg::word_t dnpc
);

    rv_isa_pkg::word_t       rs1_data, rs2_data, imm;
    rv_isa_pkg::word_t       alu_a, alu_b, alu_result, load_data, wb_data;
    rv_ctrl_pkg::imm_fmt_e   imm_fmt;
    rv_ctrl_pkg::alu_op_e    alu_op;
    rv_ctrl_pkg::alu_a_sel_e alu_a_sel;
    rv_ctrl_pkg::alu_b_sel_e alu_b_sel;
    rv_ctrl_pkg::mem_size_t  mem_size;
    logic                    less, zero;
    logic                    reg_wen, wb_from_mem, load, store, load_unsigned;
    logic                    pc_add_imm, pc_base_rs1;

    control_unit ctrl1 (
        .opcode(cmd[6:0]), .funct3(cmd[14:12]), .funct7_b5(cmd[30]),
        .less(less), .zero(zero),
        .imm_fmt(imm_fmt), .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel),
        .reg_wen(reg_wen), .wb_from_mem(wb_from_mem),
        .load(load), .store(store), .mem_size(mem_size), .load_unsigned(load_unsigned),
        .pc_add_imm(pc_add_imm), .pc_base_rs1(pc_base_rs1)
    );

    imm_decode imm1 (.cmd(cmd), .imm_fmt(imm_fmt), .imm(imm));

    // rs1, rs2, rd fields go straight to the file
    register_file rf1 (
        .clk(clk), .arst_n(arst_n),
        .raddr_a(cmd[19:15]), .raddr_b(cmd[24:20]), .waddr(cmd[11:7]),
        .wdata(wb_data), .wen(reg_wen),
        .rdata_a(rs1_data), .rdata_b(rs2_data)
    );

    // operand selects
    assign alu_a = (alu_a_sel == rv_ctrl_pkg::A_PC) ? pc : rs1_data;
    assign alu_b = (alu_b_sel == rv_ctrl_pkg::B_IMM)  ? imm :
                   (alu_b_sel == rv_ctrl_pkg::B_FOUR) ? rv_isa_pkg::word_t'(4) : rs2_data;

    alu alu1 (
        .alu_op(alu_op), .a(alu_a), .b(alu_b),
        .result(alu_result), .less(less), .zero(zero)
    );

    next_pc_unit npc1 (
        .clk(clk), .arst_n(arst_n),
        .pc_add_imm(pc_add_imm), .pc_base_rs1(pc_base_rs1),
        .imm(imm), .rs1_data(rs1_data), .pc(pc), .dnpc(dnpc)
    );

    // address computed inside, not on the alu
    data_mem dmem1 (
        .clk(clk), .arst_n(arst_n),
        .load(load), .store(store), .mem_size(mem_size), .load_unsigned(load_unsigned),
        .base(rs1_data), .offset(imm), .wdata(rs2_data), .rdata(load_data)
    );

    assign wb_data = wb_from_mem ? load_data : alu_result; // writeback source

endmodule

/* verilog/data_mem.sv */
// byte-addressed data memory
// masked synchronous stores, combinational sign/zero-extended loads
`timescale 1ns/100ps
`include "rv_params.svh"

module data_mem #(
    parameter int depth_words = `RV_DMEM_WORDS
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load,
    input  logic                   store,
    input  rv_ctrl_pkg::mem_size_t mem_size,
    input  logic                   load_unsigned,
    input  rv_isa_pkg::word_t      base,    // rs1
    input  rv_isa_pkg::word_t      offset,  // immediate
    input  rv_isa_pkg::word_t      wdata,   // rs2
    output rv_isa_pkg::word_t      rdata
);

    localparam int idx_w = $clog2(depth_words);

    rv_isa_pkg::word_t mem [depth_words];
    rv_isa_pkg::word_t addr;
    rv_isa_pkg::word_t lane_data;   // store data copied onto every lane
    rv_isa_pkg::word_t rd_shift;    // addressed bytes moved to the bottom
    logic [3:0]        wmask;
    logic [idx_w-1:0]  word_idx;

    assign addr     = base + offset;
    assign word_idx = addr[idx_w+1:2];
    assign rd_shift = mem[word_idx] >> {addr[1:0], 3'b000};

    always_comb begin
        case (mem_size)
            rv_ctrl_pkg::MEM_BYTE: wmask = 4'b0001 << addr[1:0];
            rv_ctrl_pkg::MEM_HALF: wmask = 4'b0011 << addr[1:0];
            default:               wmask = 4'b1111;
        endcase
        case (mem_size)
            rv_ctrl_pkg::MEM_BYTE: lane_data = {4{wdata[7:0]}};
            rv_ctrl_pkg::MEM_HALF: lane_data = {2{wdata[15:0]}};
            default:               lane_data = wdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (arst_n && store) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
    end

    always_comb begin
        if (!load) begin
            rdata = '0;
        end else if (mem_size == rv_ctrl_pkg::MEM_BYTE) begin
            rdata = {{24{rd_shift[7] & ~load_unsigned}}, rd_shift[7:0]};
        end else if (mem_size == rv_ctrl_pkg::MEM_HALF) begin
            rdata = {{16{rd_shift[15] & ~load_unsigned}}, rd_shift[15:0]};
        end else begin
            rdata = rd_shift;  // word, shift is zero when aligned
        end
    end

    a_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (load || store) |-> !((mem_size == rv_ctrl_pkg::MEM_HALF && addr[0]) ||
                              (mem_size == rv_ctrl_pkg::MEM_WORD && addr[1:0] != 2'b00)));
    a_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        (load || store) |-> (addr >> 2) < depth_words);

endmodule

/* verilog/next_pc_unit.sv */
// next-pc unit
// holds the pc and adds imm or four to pc or rs1
`timescale 1ns/100ps
`include "rv_params.svh"

module next_pc_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              pc_add_imm,
    input  logic              pc_base_rs1,
    input  rv_isa_pkg::word_t imm,
    input  rv_isa_pkg::word_t rs1_data,
    output rv_isa_pkg::word_t pc,
    output rv_isa_pkg::word_t dnpc
);

    rv_isa_pkg::word_t base;
    rv_isa_pkg::word_t offset;
    rv_isa_pkg::word_t sum;

    assign base   = pc_base_rs1 ? rs1_data : pc;
    assign offset = pc_add_imm ? imm : rv_isa_pkg::word_t'(4);
    assign sum    = base + offset;
    assign dnpc   = pc_base_rs1 ? {sum[`RV_XLEN-1:1], 1'b0} : sum; // jalr clears bit 0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= dnpc;  // one instruction per edge
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

/* verilog/alu.sv */
// ALU for the RV32I core
// arithmetic, logic, shifts and compares, plus less/zero flags for branches
`timescale 1ns/100ps

module alu (
    input  rv_ctrl_pkg::alu_op_e alu_op,
    input  rv_isa_pkg::word_t    a,
    input  rv_isa_pkg::word_t    b,
    output rv_isa_pkg::word_t    result,
    output logic                 less,
    output logic                 zero
);

    logic [4:0] shamt;
    logic       lt_s;   // signed a < b
    logic       lt_u;   // unsigned a < b

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (alu_op)
            rv_ctrl_pkg::ALU_ADD:    result = a + b;
            rv_ctrl_pkg::ALU_SUB:    result = a - b;
            rv_ctrl_pkg::ALU_SLL:    result = a << shamt;
            rv_ctrl_pkg::ALU_SLT:    result = rv_isa_pkg::word_t'(lt_s);
            rv_ctrl_pkg::ALU_SLTU:   result = rv_isa_pkg::word_t'(lt_u);
            rv_ctrl_pkg::ALU_XOR:    result = a ^ b;
            rv_ctrl_pkg::ALU_SRL:    result = a >> shamt;
            rv_ctrl_pkg::ALU_SRA:    result = $signed(a) >>> shamt;  // keeps sign
            rv_ctrl_pkg::ALU_OR:     result = a | b;
            rv_ctrl_pkg::ALU_AND:    result = a & b;
            rv_ctrl_pkg::ALU_PASS_B: result = b;
            default:                 result = '0;
        endcase
    end

    // signed compare only when asked, unsigned otherwise
    assign less = (alu_op == rv_ctrl_pkg::ALU_SLT) ? lt_s : lt_u;
    assign zero = (a == b);

endmodule

/* verilog/register_file.sv */
// integer register file, 2 read ports and 1 write port
// x0 has no storage and always reads zero
`timescale 1ns/100ps
`include "rv_params.svh"

module register_file #(
    parameter int n_regs = `RV_NREGS   // 16 for an rv32e-sized file
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv_isa_pkg::reg_idx_t raddr_a,
    input  rv_isa_pkg::reg_idx_t raddr_b,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_isa_pkg::word_t    wdata,
    input  logic                 wen,
    output rv_isa_pkg::word_t    rdata_a,
    output rv_isa_pkg::word_t    rdata_b
);

    rv_isa_pkg::word_t regs [1:n_regs-1];

    // index zero or beyond the file reads zero
    assign rdata_a = (raddr_a != '0 && raddr_a < n_regs) ? regs[raddr_a] : '0;
    assign rdata_b = (raddr_b != '0 && raddr_b < n_regs) ? regs[raddr_b] : '0;

    always_ff @(posedge clk) begin
        if (arst_n && wen && waddr != '0 && waddr < n_regs) regs[waddr] <= wdata; // no write in reset
    end

endmodule

/* verilog/imm_decode.sv */
// immediate generator
// reorders and sign-extends the I, S, B, U and J immediates
`timescale 1ns/100ps

module imm_decode (
    input  rv_isa_pkg::word_t     cmd,
    input  rv_ctrl_pkg::imm_fmt_e imm_fmt,
    output rv_isa_pkg::word_t     imm
);

    always_comb begin
        case (imm_fmt)
            rv_ctrl_pkg::IMM_I: imm = {{20{cmd[31]}}, cmd[31:20]};
            rv_ctrl_pkg::IMM_S: imm = {{20{cmd[31]}}, cmd[31:25], cmd[11:7]};
            // branch offset in halfwords, lsb forced low
            rv_ctrl_pkg::IMM_B: imm = {{19{cmd[31]}}, cmd[31], cmd[7], cmd[30:25],
                                       cmd[11:8], 1'b0};
            rv_ctrl_pkg::IMM_U: imm = {cmd[31:12], 12'b0};  // upper 20 bits
            rv_ctrl_pkg::IMM_J: imm = {{11{cmd[31]}}, cmd[31], cmd[19:12], cmd[20],
                                       cmd[30:21], 1'b0};
            default:            imm = '0;
        endcase
    end

endmodule

/* verilog/control_unit.sv */
// decoder and control unit
// turns opcode, funct3 and bit 30 into datapath controls, resolves branches
`timescale 1ns/100ps

module control_unit (
    input  rv_isa_pkg::opcode_t     opcode,
    input  rv_isa_pkg::funct3_t     funct3,
    input  logic                    funct7_b5,     // cmd[30]
    input  logic                    less,
    input  logic                    zero,
    output rv_ctrl_pkg::imm_fmt_e   imm_fmt,
    output rv_ctrl_pkg::alu_op_e    alu_op,
    output rv_ctrl_pkg::alu_a_sel_e alu_a_sel,
    output rv_ctrl_pkg::alu_b_sel_e alu_b_sel,
    output logic                    reg_wen,
    output logic                    wb_from_mem,   // load result to rd
    output logic                    load,
    output logic                    store,
    output rv_ctrl_pkg::mem_size_t  mem_size,
    output logic                    load_unsigned,
    output logic                    pc_add_imm,    // offset imm, else four
    output logic                    pc_base_rs1    // base rs1, else pc
);

    rv_ctrl_pkg::alu_op_e arith_op;  // op / op-imm operation
    rv_ctrl_pkg::alu_op_e cmp_op;    // branch compare flavour
    logic                 br_taken;
    logic                 is_op;

    assign is_op = (opcode == rv_isa_pkg::OPC_OP); // sub only exists for reg-reg

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_op && funct7_b5) ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            3'b001:  arith_op = rv_ctrl_pkg::ALU_SLL;
            3'b010:  arith_op = rv_ctrl_pkg::ALU_SLT;
            3'b011:  arith_op = rv_ctrl_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_ctrl_pkg::ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            3'b110:  arith_op = rv_ctrl_pkg::ALU_OR;
            default: arith_op = rv_ctrl_pkg::ALU_AND;
        endcase
    end

    // beq/bne look at zero only, which the alu gives for any op
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ, rv_isa_pkg::F3_BNE:  cmp_op = rv_ctrl_pkg::ALU_SUB;
            rv_isa_pkg::F3_BLT, rv_isa_pkg::F3_BGE:  cmp_op = rv_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU: cmp_op = rv_ctrl_pkg::ALU_SLTU;
            default:                                 cmp_op = rv_ctrl_pkg::ALU_SUB;
        endcase
    end

    // bit 2 picks less vs zero, bit 0 inverts
    assign br_taken = (funct3[2] ? less : zero) ^ funct3[0];

    always_comb begin
        // no-op defaults: fence, system, unknown opcodes
        imm_fmt       = rv_ctrl_pkg::IMM_I;
        alu_op        = rv_ctrl_pkg::ALU_ADD;
        alu_a_sel     = rv_ctrl_pkg::A_RS1;
        alu_b_sel     = rv_ctrl_pkg::B_RS2;
        reg_wen       = 1'b0;
        wb_from_mem   = 1'b0;
        load          = 1'b0;
        store         = 1'b0;
        pc_add_imm    = 1'b0;
        pc_base_rs1   = 1'b0;
        load_unsigned = (funct3 == rv_isa_pkg::F3_BYTE_U) || (funct3 == rv_isa_pkg::F3_HALF_U);
        case (funct3)
            rv_isa_pkg::F3_BYTE, rv_isa_pkg::F3_BYTE_U: mem_size = rv_ctrl_pkg::MEM_BYTE;
            rv_isa_pkg::F3_HALF, rv_isa_pkg::F3_HALF_U: mem_size = rv_ctrl_pkg::MEM_HALF;
            default:                                    mem_size = rv_ctrl_pkg::MEM_WORD;
        endcase
        case (opcode)
            rv_isa_pkg::OPC_LUI: begin
                imm_fmt   = rv_ctrl_pkg::IMM_U;
                alu_op    = rv_ctrl_pkg::ALU_PASS_B;
                alu_b_sel = rv_ctrl_pkg::B_IMM;
                reg_wen   = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                imm_fmt   = rv_ctrl_pkg::IMM_U;
                alu_a_sel = rv_ctrl_pkg::A_PC;
                alu_b_sel = rv_ctrl_pkg::B_IMM;
                reg_wen   = 1'b1;
            end
            rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
                imm_fmt     = (opcode == rv_isa_pkg::OPC_JAL) ? rv_ctrl_pkg::IMM_J
                                                              : rv_ctrl_pkg::IMM_I;
                alu_a_sel   = rv_ctrl_pkg::A_PC;    // link = pc + 4
                alu_b_sel   = rv_ctrl_pkg::B_FOUR;
                reg_wen     = 1'b1;
                pc_add_imm  = 1'b1;
                pc_base_rs1 = (opcode == rv_isa_pkg::OPC_JALR);
            end
            rv_isa_pkg::OPC_BRANCH: begin
                imm_fmt    = rv_ctrl_pkg::IMM_B;
                alu_op     = cmp_op;               // rs1 against rs2
                pc_add_imm = br_taken;
            end
            rv_isa_pkg::OPC_LOAD: begin
                reg_wen     = 1'b1;
                wb_from_mem = 1'b1;
                load        = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                imm_fmt = rv_ctrl_pkg::IMM_S;
                store   = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                alu_op    = arith_op;
                alu_b_sel = rv_ctrl_pkg::B_IMM;
                reg_wen   = 1'b1;
            end
            rv_isa_pkg::OPC_OP: begin
                alu_op  = arith_op;
                reg_wen = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/rv_ctrl_pkg.sv */
// datapath control encodings of the core
// alu operation, immediate format, operand selects, memory size
package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui path
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

    typedef enum logic {A_RS1, A_PC} alu_a_sel_e;

    typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} alu_b_sel_e; // four for link

    // access size, matches funct3[1:0]
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t MEM_BYTE = 2'd0;
    localparam mem_size_t MEM_HALF = 2'd1;
    localparam mem_size_t MEM_WORD = 2'd2;

endpackage

/* verilog/rv_isa_pkg.sv */
// RV32I instruction set encodings
// opcodes, funct3 codes, word and register index types
`include "rv_params.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t; // data, pc, instruction
    typedef logic [4:0]          reg_idx_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [2:0]          funct3_t;

    // opcode groups the core acts on
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // load/store sizes, stores use the signed codes
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

endpackage

/* verilog/rv_params.svh */
// core parameters for the RV32I single-cycle core
// widths, register count, reset pc, data memory depth
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path width, also pc and instruction width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NREGS 32

`define RV_RESET_PC 32'h0000_0000 // first fetch address

// data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

`endif
